/* hw/decode.sv */
module decode import rs_pkg::*; #(
    parameter int XLEN = 32,
    parameter int NUM_REGS = 8
) (
    input  logic clock,
    input  logic reset,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  logic [3:0] wb_adr,
    input  logic [XLEN-1:0] wb_dat_w,
    output logic [XLEN-1:0] wb_dat_r,
    output logic wb_ack,
    input  logic [NUM_ENTRIES-1:0] entry_busy,
    input  logic cdb_valid,
    input  logic [TAG_W-1:0] cdb_tag,
    input  logic [XLEN-1:0] cdb_value,
    output logic disp_valid,
    output logic [TAG_W-1:0] disp_entry,
    output alu_op_e disp_op,
    output logic [XLEN-1:0] disp_imm,
    output logic [TAG_W-1:0] disp_src1_tag,
    output logic disp_src1_wait,
    output logic [XLEN-1:0] disp_src1_val,
    output logic [TAG_W-1:0] disp_src2_tag,
    output logic disp_src2_wait,
    output logic [XLEN-1:0] disp_src2_val
);
    localparam int RIDX_W = $clog2(NUM_REGS);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic [NUM_REGS-1:0] alias_v;
    logic [TAG_W-1:0] alias_tag [NUM_REGS];

    opcode_e opcode;
    alu_op_e op;
    fu_type_e cls;
    logic [XLEN-1:0] imm;
    logic [RIDX_W-1:0] rd;
    logic [RIDX_W-1:0] src_idx [2];
    logic [1:0] src_wait;
    logic [TAG_W-1:0] src_tag [2];
    logic [XLEN-1:0] src_val [2];
    logic [TAG_W-1:0] pick;
    logic pick_ok;
    logic ld_pend;
    logic st_pend;
    logic can_disp;
    logic renames;
    logic wb_req;
    logic wr_go;
    logic ack_go;
    logic rd_ok;
    logic [RIDX_W-1:0] rd_idx;

    always_comb begin
        opcode = opcode_e'(wb_dat_w[6:0]);
        rd = wb_dat_w[7 +: RIDX_W];
        src_idx[0] = wb_dat_w[15 +: RIDX_W];
        src_idx[1] = wb_dat_w[20 +: RIDX_W];
        op = alu_add;
        cls = fu_alu;
        imm = {{(XLEN-12){wb_dat_w[31]}}, wb_dat_w[31:20]};
        case (opcode)
            op_reg: begin
                if (wb_dat_w[25]) begin // funct7 of the M extension.
                    op = alu_mul;
                    cls = fu_mul;
                end else begin
                    case (wb_dat_w[14:12])
                        3'b100: op = alu_xor;
                        3'b110: op = alu_or;
                        3'b111: op = alu_and;
                        default: op = wb_dat_w[30] ? alu_sub : alu_add;
                    endcase
                end
            end
            op_load: cls = fu_load;
            op_store: begin
                cls = fu_store;
                imm = {{(XLEN-12){wb_dat_w[31]}}, wb_dat_w[31:25], wb_dat_w[11:7]};
            end
            default: ;
        endcase

        // x0 is never renamed and never written, so it reads as zero.
        for (int s = 0; s < 2; s++) begin
            src_wait[s] = 1'b0;
            src_tag[s] = alias_tag[src_idx[s]];
            src_val[s] = regs[src_idx[s]];
            if (alias_v[src_idx[s]]) begin
                if (cdb_valid && cdb_tag == alias_tag[src_idx[s]])
                    src_val[s] = cdb_value;
                else
                    src_wait[s] = 1'b1;
            end
        end
        if (opcode == op_imm || opcode == op_load) begin
            src_wait[1] = 1'b0;
            src_val[1] = imm;
        end

        pick_ok = 1'b0;
        pick = '0;
        ld_pend = 1'b0;
        st_pend = 1'b0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (ENTRY_FU[i] == cls && !entry_busy[i]) begin
                pick_ok = 1'b1;
                pick = TAG_W'(i);
            end
            if (ENTRY_FU[i] == fu_load)
                ld_pend = ld_pend | entry_busy[i];
            if (ENTRY_FU[i] == fu_store)
                st_pend = st_pend | entry_busy[i];
        end
        can_disp = pick_ok && !(cls == fu_load && st_pend) && !(cls == fu_store && ld_pend);
    end

    assign renames = cls != fu_store && rd != '0;
    assign wb_req = wb_cyc && wb_stb && !wb_ack;
    assign wr_go = wb_req && wb_we && wb_adr == 4'd0 && can_disp;
    assign rd_idx = RIDX_W'(wb_adr);
    assign rd_ok = (wb_adr < NUM_REGS) ? !alias_v[rd_idx] : 1'b1; // Wait for the pending value.
    assign ack_go = wb_req && (wb_we ? (wb_adr != 4'd0 || can_disp) : rd_ok);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wb_ack <= 1'b0;
            disp_valid <= 1'b0;
            alias_v <= '0;
            for (int r = 0; r < NUM_REGS; r++)
                regs[r] <= '0;
        end else begin
            wb_ack <= ack_go;
            disp_valid <= wr_go;
            for (int r = 0; r < NUM_REGS; r++) begin
                if (cdb_valid && alias_v[r] && alias_tag[r] == cdb_tag) begin
                    regs[r] <= cdb_value;
                    alias_v[r] <= 1'b0;
                end
            end
            if (wr_go && renames)
                alias_v[rd] <= 1'b1; // A newer rename overrides the clear above.
        end
    end

    always_ff @(posedge clock) begin
        if (wr_go && renames)
            alias_tag[rd] <= pick;
        if (ack_go && !wb_we)
            wb_dat_r <= (wb_adr < NUM_REGS) ? regs[rd_idx] : '0;
        if (wr_go) begin
            disp_entry <= pick;
            disp_op <= op;
            disp_imm <= imm;
            disp_src1_tag <= src_tag[0];
            disp_src1_wait <= src_wait[0];
            disp_src1_val <= src_val[0];
            disp_src2_tag <= src_tag[1];
            disp_src2_wait <= src_wait[1];
            disp_src2_val <= src_val[1];
        end
    end

endmodule

/* hw/exec_units.sv */
module exec_units import rs_pkg::*; #(
    parameter int XLEN = 32,
    parameter int MEM_WORDS = 16,
    parameter int MUL_STAGES = 3
) (
    input  logic clock,
    input  logic reset,
    input  logic [NUM_FU-1:0] issue_valid,
    input  logic [TAG_W-1:0] issue_entry [NUM_FU],
    input  alu_op_e issue_op [NUM_FU],
    input  logic [XLEN-1:0] issue_a [NUM_FU],
    input  logic [XLEN-1:0] issue_b [NUM_FU],
    input  logic [XLEN-1:0] issue_imm [NUM_FU],
    input  logic [NUM_PROD-1:0] grant,
    output logic [NUM_ENTRIES-1:0] unit_ready,
    output logic [NUM_PROD-1:0] done_valid,
    output logic [XLEN-1:0] done_value [NUM_PROD],
    output logic store_done
);
    localparam int MEM_AW = $clog2(MEM_WORDS);
    localparam int LAST = MUL_STAGES - 1;

    logic [XLEN-1:0] mem [MEM_WORDS];
    logic [1:0] alu_go;
    logic [1:0] alu_v;
    logic [XLEN-1:0] alu_r [2];
    logic [XLEN-1:0] alu_y;
    logic [MUL_STAGES-1:0] mul_v;
    logic [XLEN-1:0] mul_p [MUL_STAGES];
    logic ld_v;
    logic [XLEN-1:0] ld_r;
    logic [XLEN-1:0] ld_sum;
    logic [XLEN-1:0] st_sum;

    function automatic logic [XLEN-1:0] alu_f(alu_op_e f, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        case (f)
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            default: return a + b; // addi arrives with the immediate as operand b.
        endcase
    endfunction

    assign alu_y = alu_f(issue_op[fu_alu], issue_a[fu_alu], issue_b[fu_alu]);
    assign alu_go[0] = issue_valid[fu_alu] && issue_entry[fu_alu] == TAG_W'(0);
    assign alu_go[1] = issue_valid[fu_alu] && issue_entry[fu_alu] == TAG_W'(1);
    assign ld_sum = issue_a[fu_load] + issue_imm[fu_load];
    assign st_sum = issue_a[fu_store] + issue_imm[fu_store];

    // A unit takes new work once its result leaves this cycle.
    assign unit_ready[0] = !alu_v[0] || grant[0];
    assign unit_ready[1] = !alu_v[1] || grant[1];
    assign unit_ready[2] = !(|mul_v) || grant[2];
    assign unit_ready[3] = !ld_v || grant[3];
    assign unit_ready[4] = 1'b1;

    assign done_valid = {ld_v, mul_v[LAST], alu_v};
    assign done_value[0] = alu_r[0];
    assign done_value[1] = alu_r[1];
    assign done_value[2] = mul_p[LAST];
    assign done_value[3] = ld_r;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_v <= '0;
            mul_v <= '0;
            ld_v <= 1'b0;
            store_done <= 1'b0;
            for (int w = 0; w < MEM_WORDS; w++)
                mem[w] <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (grant[i])
                    alu_v[i] <= 1'b0;
                if (alu_go[i])
                    alu_v[i] <= 1'b1;
            end
            // The last stage holds its product until the bus takes it.
            mul_v[0] <= issue_valid[fu_mul] || (LAST == 0 && mul_v[0] && !grant[2]);
            for (int k = 1; k < MUL_STAGES; k++)
                mul_v[k] <= mul_v[k-1] || (k == LAST && mul_v[k] && !grant[2]);
            if (grant[3])
                ld_v <= 1'b0;
            if (issue_valid[fu_load])
                ld_v <= 1'b1;
            if (issue_valid[fu_store])
                mem[st_sum[MEM_AW+1:2]] <= issue_b[fu_store];
            store_done <= issue_valid[fu_store];
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < 2; i++) begin
            if (alu_go[i])
                alu_r[i] <= alu_y;
        end
        if (issue_valid[fu_mul])
            mul_p[0] <= issue_a[fu_mul] * issue_b[fu_mul];
        for (int k = 1; k < MUL_STAGES; k++) begin
            if (mul_v[k-1])
                mul_p[k] <= mul_p[k-1];
        end
        if (issue_valid[fu_load])
            ld_r <= mem[ld_sum[MEM_AW+1:2]];
    end

endmodule

/* hw/ooo_core.sv */
module ooo_core import rs_pkg::*; #(
    parameter int XLEN = 32,
    parameter int NUM_REGS = 8,
    parameter int MEM_WORDS = 16,
    parameter int MUL_STAGES = 3
) (
    input  logic clock,
    input  logic reset,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  logic [3:0] wb_adr,
    input  logic [XLEN-1:0] wb_dat_w,
    output logic [XLEN-1:0] wb_dat_r,
    output logic wb_ack
);
    logic disp_valid;
    logic [TAG_W-1:0] disp_entry;
    alu_op_e disp_op;
    logic [XLEN-1:0] disp_imm;
    logic [TAG_W-1:0] disp_src1_tag;
    logic disp_src1_wait;
    logic [XLEN-1:0] disp_src1_val;
    logic [TAG_W-1:0] disp_src2_tag;
    logic disp_src2_wait;
    logic [XLEN-1:0] disp_src2_val;
    logic [NUM_ENTRIES-1:0] entry_busy;

    logic [NUM_FU-1:0] issue_valid;
    logic [TAG_W-1:0] issue_entry [NUM_FU];
    alu_op_e issue_op [NUM_FU];
    logic [XLEN-1:0] issue_a [NUM_FU];
    logic [XLEN-1:0] issue_b [NUM_FU];
    logic [XLEN-1:0] issue_imm [NUM_FU];
    logic [NUM_ENTRIES-1:0] unit_ready;

    logic [NUM_PROD-1:0] done_valid;
    logic [XLEN-1:0] done_value [NUM_PROD];
    logic [NUM_PROD-1:0] grant;
    logic store_done;

    logic cdb_valid; // Single result broadcast shared by decode and the station.
    logic [TAG_W-1:0] cdb_tag;
    logic [XLEN-1:0] cdb_value;

    decode #(.XLEN(XLEN), .NUM_REGS(NUM_REGS)) u_decode (.*);

    rs #(.XLEN(XLEN)) u_rs (.*);

    exec_units #(
        .XLEN(XLEN),
        .MEM_WORDS(MEM_WORDS),
        .MUL_STAGES(MUL_STAGES)
    ) u_exec (.*);

    result_bus #(.XLEN(XLEN)) u_result_bus (.*);

endmodule

/* hw/result_bus.sv */
module result_bus import rs_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic clock,
    input  logic reset,
    input  logic [NUM_PROD-1:0] done_valid,
    input  logic [XLEN-1:0] done_value [NUM_PROD],
    output logic [NUM_PROD-1:0] grant,
    output logic cdb_valid,
    output logic [TAG_W-1:0] cdb_tag,
    output logic [XLEN-1:0] cdb_value
);
    // Load first, then MUL, then ALU entries 0 and 1.
    localparam int PRIO [NUM_PROD] = '{3, 2, 0, 1};

    logic [TAG_W-1:0] win_tag;
    logic [XLEN-1:0] win_value;

    always_comb begin
        grant = '0;
        win_tag = '0;
        win_value = '0;
        for (int p = NUM_PROD - 1; p >= 0; p--) begin
            if (done_valid[PRIO[p]]) begin
                grant = '0;
                grant[PRIO[p]] = 1'b1;
                win_tag = TAG_W'(PRIO[p]);
                win_value = done_value[PRIO[p]];
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            cdb_valid <= 1'b0;
        else
            cdb_valid <= |done_valid;
    end

    always_ff @(posedge clock) begin
        if (|done_valid) begin
            cdb_tag <= win_tag;
            cdb_value <= win_value;
        end
    end

endmodule

/* hw/rs.sv */
module rs import rs_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic clock,
    input  logic reset,
    input  logic disp_valid,
    input  logic [TAG_W-1:0] disp_entry,
    input  alu_op_e disp_op,
    input  logic [XLEN-1:0] disp_imm,
    input  logic [TAG_W-1:0] disp_src1_tag,
    input  logic disp_src1_wait,
    input  logic [XLEN-1:0] disp_src1_val,
    input  logic [TAG_W-1:0] disp_src2_tag,
    input  logic disp_src2_wait,
    input  logic [XLEN-1:0] disp_src2_val,
    input  logic [NUM_ENTRIES-1:0] unit_ready,
    input  logic cdb_valid,
    input  logic [TAG_W-1:0] cdb_tag,
    input  logic [XLEN-1:0] cdb_value,
    input  logic store_done,
    output logic [NUM_ENTRIES-1:0] entry_busy,
    output logic [NUM_FU-1:0] issue_valid,
    output logic [TAG_W-1:0] issue_entry [NUM_FU],
    output alu_op_e issue_op [NUM_FU],
    output logic [XLEN-1:0] issue_a [NUM_FU],
    output logic [XLEN-1:0] issue_b [NUM_FU],
    output logic [XLEN-1:0] issue_imm [NUM_FU]
);
    logic [NUM_ENTRIES-1:0] busy;
    logic [NUM_ENTRIES-1:0] issued;
    logic [NUM_ENTRIES-1:0] wait_a;
    logic [NUM_ENTRIES-1:0] wait_b;
    logic [NUM_ENTRIES-1:0] wake_a;
    logic [NUM_ENTRIES-1:0] wake_b;
    logic [NUM_ENTRIES-1:0] go;
    alu_op_e op [NUM_ENTRIES];
    logic [XLEN-1:0] opa [NUM_ENTRIES];
    logic [XLEN-1:0] opb [NUM_ENTRIES];
    logic [XLEN-1:0] imm [NUM_ENTRIES];
    logic [TAG_W-1:0] tag_a [NUM_ENTRIES];
    logic [TAG_W-1:0] tag_b [NUM_ENTRIES];
    logic hit1;
    logic hit2;

    assign entry_busy = busy;

    // A broadcast during the dispatch cycle fills the new entry directly.
    assign hit1 = cdb_valid && disp_src1_wait && disp_src1_tag == cdb_tag;
    assign hit2 = cdb_valid && disp_src2_wait && disp_src2_tag == cdb_tag;

    always_comb begin
        issue_valid = '0;
        go = '0;
        for (int c = 0; c < NUM_FU; c++) begin
            issue_entry[c] = '0;
            issue_op[c] = alu_add;
            issue_a[c] = '0;
            issue_b[c] = '0;
            issue_imm[c] = '0;
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            wake_a[i] = cdb_valid && wait_a[i] && tag_a[i] == cdb_tag;
            wake_b[i] = cdb_valid && wait_b[i] && tag_b[i] == cdb_tag;
            // Lowest ready entry of each class wins its unit.
            if (busy[i] && !issued[i] && !wait_a[i] && !wait_b[i] && unit_ready[i] &&
                !issue_valid[ENTRY_FU[i]]) begin
                go[i] = 1'b1;
                issue_valid[ENTRY_FU[i]] = 1'b1;
                issue_entry[ENTRY_FU[i]] = TAG_W'(i);
                issue_op[ENTRY_FU[i]] = op[i];
                issue_a[ENTRY_FU[i]] = opa[i];
                issue_b[ENTRY_FU[i]] = opb[i];
                issue_imm[ENTRY_FU[i]] = imm[i];
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= '0;
            issued <= '0;
            wait_a <= '0;
            wait_b <= '0;
        end else begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (wake_a[i])
                    wait_a[i] <= 1'b0;
                if (wake_b[i])
                    wait_b[i] <= 1'b0;
                if (go[i])
                    issued[i] <= 1'b1;
                if ((cdb_valid && cdb_tag == TAG_W'(i)) ||
                    (store_done && ENTRY_FU[i] == fu_store)) begin
                    busy[i] <= 1'b0;
                    issued[i] <= 1'b0;
                end
                if (disp_valid && disp_entry == TAG_W'(i)) begin
                    busy[i] <= 1'b1;
                    issued[i] <= 1'b0;
                    wait_a[i] <= disp_src1_wait && !hit1;
                    wait_b[i] <= disp_src2_wait && !hit2;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (disp_valid && disp_entry == TAG_W'(i)) begin
                op[i] <= disp_op;
                imm[i] <= disp_imm;
                tag_a[i] <= disp_src1_tag;
                tag_b[i] <= disp_src2_tag;
                opa[i] <= hit1 ? cdb_value : disp_src1_val;
                opb[i] <= hit2 ? cdb_value : disp_src2_val;
            end else begin
                if (wake_a[i])
                    opa[i] <= cdb_value;
                if (wake_b[i])
                    opb[i] <= cdb_value;
            end
        end
    end

endmodule

/* hw/rs_pkg.sv */
package rs_pkg;

    typedef enum logic [1:0] {
        fu_alu,
        fu_mul,
        fu_load,
        fu_store
    } fu_type_e;

    // RISC-V major opcodes of the supported subset.
    typedef enum logic [6:0] {
        op_load  = 7'b0000011,
        op_imm   = 7'b0010011,
        op_store = 7'b0100011,
        op_reg   = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_mul
    } alu_op_e;

    localparam int NUM_ENTRIES = 5;
    localparam int NUM_PROD = NUM_ENTRIES - 1; // The store entry is last and produces nothing.
    localparam int NUM_FU = 4;
    localparam int TAG_W = 3;

    // Each entry is tied to one unit class.
    localparam fu_type_e ENTRY_FU [NUM_ENTRIES] = '{fu_alu, fu_alu, fu_mul, fu_load, fu_store};

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_top -f src.f -o tb_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/tb_sim 2>&1)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Simulation finished: PASS" <<< "$sim_output"; then
    exit 0
fi

echo "Pass line not found in the simulation output"
exit 1

/* src.f */
hw/rs_pkg.sv
hw/decode.sv
hw/rs.sv
hw/exec_units.sv
hw/result_bus.sv
hw/ooo_core.sv
verif/rs_props.sv
verif/tb_top.sv

/* verif/rs_props.sv */
module rs_props import rs_pkg::*; (
    input logic clock,
    input logic reset,
    input logic disp_valid,
    input logic [TAG_W-1:0] disp_entry,
    input logic [NUM_ENTRIES-1:0] busy,
    input logic [NUM_ENTRIES-1:0] issued,
    input logic [NUM_ENTRIES-1:0] wait_a,
    input logic [NUM_ENTRIES-1:0] wait_b,
    input logic [NUM_FU-1:0] issue_valid,
    input logic [TAG_W-1:0] issue_entry [NUM_FU],
    input logic cdb_valid,
    input logic [TAG_W-1:0] cdb_tag
);

    // Decode only ever hands an instruction to an idle entry.
    a_disp_free: assert property (@(posedge clock) disable iff (reset)
        disp_valid |-> !busy[disp_entry])
    else $error("Dispatch targeted a reservation station entry that was already busy.");

    for (genvar c = 0; c < NUM_FU; c++) begin : g_issue
        a_issue_ready: assert property (@(posedge clock) disable iff (reset)
            issue_valid[c] |-> busy[issue_entry[c]] && !wait_a[issue_entry[c]] &&
                !wait_b[issue_entry[c]])
        else $error("An entry issued while idle or still waiting on an operand.");
    end

    a_cdb_owner: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> busy[cdb_tag] && issued[cdb_tag]) // Only executed work broadcasts.
    else $error("The broadcast tag named an entry that was not busy and issued.");

endmodule

bind rs rs_props u_rs_props (
    .clock(clock),
    .reset(reset),
    .disp_valid(disp_valid),
    .disp_entry(disp_entry),
    .busy(busy),
    .issued(issued),
    .wait_a(wait_a),
    .wait_b(wait_b),
    .issue_valid(issue_valid),
    .issue_entry(issue_entry),
    .cdb_valid(cdb_valid),
    .cdb_tag(cdb_tag)
);

/* verif/tb_top.sv */
module tb_top;
    localparam int XLEN = 32;
    localparam int NUM_REGS = 8;
    localparam int MEM_WORDS = 16;
    localparam int NUM_RANDOM = 300;
    localparam int NUM_INSTR = NUM_RANDOM + 40; // The directed tests add fewer than forty.
    localparam int ACK_LIMIT = 200;
    localparam int PERIOD = 4;

    // RISC-V encodings of the subset, straight from the ISA manual.
    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] F7_SUB = 7'b0100000;
    localparam logic [6:0] F7_MUL = 7'b0000001;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    logic clock;
    logic reset;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [3:0] wb_adr;
    logic [XLEN-1:0] wb_dat_w;
    logic [XLEN-1:0] wb_dat_r;
    logic wb_ack;

    logic [XLEN-1:0] model_regs [NUM_REGS];
    logic [XLEN-1:0] model_mem [MEM_WORDS];

    ooo_core #(
        .XLEN(XLEN),
        .NUM_REGS(NUM_REGS),
        .MEM_WORDS(MEM_WORDS),
        .MUL_STAGES(3)
    ) uut (.*);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    initial begin
        #((NUM_INSTR * 200 + 1000) * PERIOD);
        abort_run("Watchdog expired before all tests had finished.");
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first error.");
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, (opc == OPC_LOAD) ? 3'b010 : 3'b000, rd, opc}; // lw has funct3 2.
    endfunction

    function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] random_instr();
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [11:0] imm;
        rd = 5'($urandom_range(7, 1));
        rs1 = 5'($urandom_range(7, 0));
        rs2 = 5'($urandom_range(7, 0));
        imm = 12'($urandom);
        case ($urandom_range(9, 0))
            0: return r_type(7'd0, 3'b000, rd, rs1, rs2);
            1: return r_type(F7_SUB, 3'b000, rd, rs1, rs2);
            2: return r_type(7'd0, F3_AND, rd, rs1, rs2);
            3: return r_type(7'd0, F3_OR, rd, rs1, rs2);
            4: return r_type(7'd0, F3_XOR, rd, rs1, rs2);
            5, 6: return r_type(F7_MUL, 3'b000, rd, rs1, rs2);
            7: return i_type(OPC_IMM, rd, rs1, imm);
            8: return i_type(OPC_LOAD, rd, rs1, imm);
            default: return s_type(rs2, rs1, imm);
        endcase
    endfunction

    // Holds the request until ack, then releases the bus.
    task automatic wait_ack(input string what);
        int waited;
        waited = 0;
        do begin
            @(posedge clock);
            #1;
            waited++;
            if (waited > ACK_LIMIT)
                abort_run($sformatf("No Wishbone ack for a %s within %0d cycles.", what, ACK_LIMIT));
        end while (!wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_write(input logic [XLEN-1:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b1;
        wb_adr = 4'd0;
        wb_dat_w = data;
        wait_ack("instruction write");
    endtask

    task automatic check_reg(input int r);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b0;
        wb_adr = 4'(r);
        wait_ack("register read");
        assert (wb_dat_r === model_regs[r])
        else abort_run($sformatf("[FAIL] %0t: x%0d read %h, expected %h",
                                 $time, r, wb_dat_r, model_regs[r]));
    endtask

    task automatic check_all();
        for (int r = 0; r < NUM_REGS; r++)
            check_reg(r);
    endtask

    // Executes one instruction in program order on the model, then sends it.
    task automatic run_instr(input logic [31:0] ins);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] res;
        logic writes;
        a = model_regs[ins[17:15]];
        b = model_regs[ins[22:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        res = '0;
        writes = 1'b1;
        case (ins[6:0])
            OPC_REG: begin
                if (ins[31:25] == F7_MUL)
                    res = a * b;
                else if (ins[14:12] == F3_XOR)
                    res = a ^ b;
                else if (ins[14:12] == F3_OR)
                    res = a | b;
                else if (ins[14:12] == F3_AND)
                    res = a & b;
                else
                    res = (ins[31:25] == F7_SUB) ? a - b : a + b;
            end
            OPC_IMM: res = a + imm_i;
            OPC_LOAD: begin
                addr = a + imm_i;
                res = model_mem[addr[5:2]];
            end
            default: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                model_mem[addr[5:2]] = b;
                writes = 1'b0;
            end
        endcase
        if (writes && ins[9:7] != 3'd0)
            model_regs[ins[9:7]] = res;
        wb_write(ins);
    endtask

    initial begin
        void'($urandom(32'h5ec9_a1dd));
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 4'd0;
        wb_dat_w = '0;
        for (int r = 0; r < NUM_REGS; r++)
            model_regs[r] = '0;
        for (int w = 0; w < MEM_WORDS; w++)
            model_mem[w] = '0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        check_all();
        run_instr(i_type(OPC_IMM, 0, 0, 12'd5)); // x0 must stay zero.
        check_reg(0);

        // Dependent chain through the alias table.
        run_instr(i_type(OPC_IMM, 1, 0, 12'd7));
        run_instr(i_type(OPC_IMM, 2, 1, 12'd3));
        run_instr(r_type(7'd0, 3'b000, 3, 2, 1));
        run_instr(r_type(F7_SUB, 3'b000, 4, 3, 2));
        run_instr(r_type(7'd0, F3_XOR, 5, 4, 3));
        run_instr(r_type(7'd0, F3_OR, 6, 5, 1));
        run_instr(r_type(7'd0, F3_AND, 7, 6, 3));
        run_instr(i_type(OPC_IMM, 1, 7, 12'hfff));
        check_all();

        // Multiply overtaken by younger ALU work, and x2 rewritten behind it.
        run_instr(r_type(F7_MUL, 3'b000, 2, 1, 3));
        run_instr(i_type(OPC_IMM, 2, 0, 12'd9));
        run_instr(r_type(7'd0, 3'b000, 4, 1, 1));
        run_instr(i_type(OPC_IMM, 5, 0, 12'd100));
        run_instr(r_type(F7_MUL, 3'b000, 6, 2, 2));
        run_instr(r_type(7'd0, F3_XOR, 7, 4, 5));
        check_all();

        // Stores and loads to the same and to different words.
        run_instr(i_type(OPC_IMM, 1, 0, 12'd12));
        run_instr(s_type(5, 1, 12'd0));
        run_instr(s_type(4, 1, 12'd4));
        run_instr(i_type(OPC_LOAD, 3, 1, 12'd0));
        run_instr(i_type(OPC_LOAD, 6, 0, 12'd4));
        run_instr(i_type(OPC_IMM, 2, 0, 12'd16));
        run_instr(i_type(OPC_LOAD, 7, 2, 12'hffc));
        run_instr(s_type(3, 0, 12'd8));
        run_instr(i_type(OPC_LOAD, 4, 0, 12'd8));
        check_all();

        for (int i = 0; i < NUM_RANDOM; i++) begin
            run_instr(random_instr());
            if ((i + 1) % 50 == 0)
                check_all();
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
